//--- src/uart_calc_pkg.sv
/*
 * serial calculator shared definitions
 * byte and digit types, oversample counters, parser states
 * and the character codes the command parser looks for
 */

package uart_calc_pkg;

    // ------------------------------
    // vector types
    // ------------------------------
    typedef logic [7:0] byte_t;      // one serial character
    typedef logic [3:0] digit_t;     // decimal digit value 0..9
    typedef logic [3:0] os_cnt_t;    // phase within one bit
    typedef logic [2:0] bit_idx_t;   // data bit index

    // command parser states
    typedef enum logic [1:0] {
        WAIT_D1,                     // expecting first digit
        WAIT_D2,                     // expecting second digit
        WAIT_OP                      // expecting '+' or '-'
    } parser_state_t;

    localparam int OVERSAMPLE = 16;  // ticks per bit

    // ------------------------------
    // character codes
    // ------------------------------
    localparam byte_t ASCII_ZERO  = 8'h30;
    localparam byte_t ASCII_NINE  = 8'h39;
    localparam byte_t ASCII_PLUS  = 8'h2B;
    localparam byte_t ASCII_MINUS = 8'h2D;
    localparam byte_t ASCII_ESC   = 8'h1B;  // clears a half-typed command

endpackage

//--- src/uart_baud_gen.sv
/*
 * baud generator
 * divides the system clock down to the 16x oversample tick
 * shared by the receiver and the transmitter
 */

`timescale 1ns/1ps

module uart_baud_gen import uart_calc_pkg::*; #(
    parameter int CLK_FREQ = 50_000_000,
    parameter int BAUD     = 115_200
) (
    input  logic CLKOP,
    input  logic i_rst,
    output logic o_os_tick
);

    localparam int DIV   = CLK_FREQ / (BAUD * OVERSAMPLE);  // clocks per tick
    localparam int CNT_W = (DIV < 2) ? 1 : $clog2(DIV);

    // a divider of 0 or 1 would leave the tick stuck high
    if (DIV < 2) begin : g_div_check
        $error("uart_baud_gen: divider %0d too small", DIV);
    end

    logic [CNT_W-1:0] div_cnt;  // counts down to zero

    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            div_cnt   <= CNT_W'(DIV - 1);
            o_os_tick <= 1'b0;
        end else if (div_cnt == '0) begin
            div_cnt   <= CNT_W'(DIV - 1);  // reload
            o_os_tick <= 1'b1;             // one pulse per wrap
        end else begin
            div_cnt   <= div_cnt - 1'b1;
            o_os_tick <= 1'b0;
        end
    end

    // rx and tx count ticks, a double-wide tick would skip a phase
    a_tick_single: assert property (@(posedge CLKOP) disable iff (i_rst)
        o_os_tick |=> !o_os_tick);

endmodule

//--- src/uart_rx.sv
/*
 * 8N1 receiver, 16x oversampled
 * two-flop synchronizer, start bit re-check at mid bit,
 * data sampled at phase 8, one-cycle strobe on a good stop bit
 */

`timescale 1ns/1ps

module uart_rx import uart_calc_pkg::*; (
    input  logic  CLKOP,
    input  logic  i_rst,
    input  logic  i_os_tick,
    input  logic  i_rx,
    output logic  o_rx_valid,
    output byte_t o_rx_byte
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    localparam os_cnt_t MID_PHASE  = os_cnt_t'(OVERSAMPLE / 2);  // sample point
    localparam os_cnt_t LAST_PHASE = os_cnt_t'(OVERSAMPLE - 1);  // bit boundary

    rx_state_t state;
    logic      rx_meta;    // first sync stage
    logic      rx_sync;    // safe to use
    os_cnt_t   os_cnt;     // phase within current bit
    bit_idx_t  bit_idx;    // data bit being received
    byte_t     shift_reg;  // LSB arrives first
    logic      mid_tick;   // tick at the bit middle

    assign mid_tick = i_os_tick && (os_cnt == MID_PHASE);

    // ------------------------------
    // input synchronizer
    // ------------------------------
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            rx_meta <= 1'b1;  // line idles high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    // ------------------------------
    // frame FSM
    // ------------------------------
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            state      <= RX_IDLE;
            os_cnt     <= '0;
            bit_idx    <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            o_rx_valid <= 1'b0;  // strobe by default low
            if (i_os_tick) begin
                os_cnt <= os_cnt + 4'd1;
                case (state)
                    RX_IDLE: begin
                        if (!rx_sync) begin
                            state  <= RX_START;
                            os_cnt <= 4'd1;  // this tick was phase 0
                        end
                    end
                    RX_START: begin
                        if (os_cnt == MID_PHASE && rx_sync) begin
                            state <= RX_IDLE;  // glitch, went back high
                        end else if (os_cnt == LAST_PHASE) begin
                            state   <= RX_DATA;
                            bit_idx <= '0;
                        end
                    end
                    RX_DATA: begin
                        if (os_cnt == LAST_PHASE) begin
                            if (bit_idx == 3'd7) begin
                                state <= RX_STOP;
                            end
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                    RX_STOP: begin
                        if (os_cnt == MID_PHASE) begin
                            o_rx_valid <= rx_sync;  // low stop bit dropped quietly
                            state      <= RX_IDLE;  // free to catch next start early
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    // data path
    always_ff @(posedge CLKOP) begin
        if (mid_tick && state == RX_DATA) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
        if (mid_tick && state == RX_STOP && rx_sync) begin
            o_rx_byte <= shift_reg;  // holds until the next strobe
        end
    end

endmodule

//--- src/uart_tx.sv
/*
 * 8N1 transmitter
 * loads a frame on a start strobe, sends start, 8 data bits
 * LSB first and stop, 16 ticks per bit, busy until stop ends
 */

`timescale 1ns/1ps

module uart_tx import uart_calc_pkg::*; (
    input  logic  CLKOP,
    input  logic  i_rst,
    input  logic  i_os_tick,
    input  logic  i_tx_start,
    input  byte_t i_tx_byte,
    output logic  o_tx_busy,
    output logic  o_tx
);

    localparam os_cnt_t LAST_PHASE = os_cnt_t'(OVERSAMPLE - 1);
    localparam int      FRAME_BITS = 10;  // start + 8 data + stop

    logic [FRAME_BITS-1:0] frame;    // bit 0 goes out next
    logic [3:0]            bit_cnt;  // 0..9 within the frame
    os_cnt_t               os_cnt;
    logic                  bit_end;  // last tick of current bit
    logic                  load;

    assign load    = i_tx_start && !o_tx_busy;
    assign bit_end = o_tx_busy && i_os_tick && (os_cnt == LAST_PHASE);

    // ------------------------------
    // control
    // ------------------------------
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            o_tx_busy <= 1'b0;
            o_tx      <= 1'b1;  // idle high
            os_cnt    <= '0;
            bit_cnt   <= '0;
        end else if (load) begin
            o_tx_busy <= 1'b1;
            os_cnt    <= '0;  // start bit goes out on the next tick
            bit_cnt   <= '0;
        end else if (o_tx_busy && i_os_tick) begin
            if (os_cnt == '0) begin
                o_tx <= frame[0];  // new bit at phase 0
            end
            os_cnt <= os_cnt + 4'd1;
            if (os_cnt == LAST_PHASE) begin
                if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                    o_tx_busy <= 1'b0;  // stop bit done, line stays high
                end
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // frame shifter
    always_ff @(posedge CLKOP) begin
        if (load) begin
            frame <= {1'b1, i_tx_byte, 1'b0};
        end else if (bit_end) begin
            frame <= frame >> 1;
        end
    end

    // the arbiter must wait for busy to fall before the next byte
    a_no_start_busy: assert property (@(posedge CLKOP) disable iff (i_rst)
        i_tx_start |-> !o_tx_busy);

endmodule

//--- src/calc_cmd_parser.sv
/*
 * command parser for digit, digit, operator
 * echoes every character except ESC, sends '0' plus sum or
 * difference after '+' or '-', ESC or a bad char restarts
 */

`timescale 1ns/1ps

module calc_cmd_parser import uart_calc_pkg::*; (
    input  logic  CLKOP,
    input  logic  i_rst,
    input  logic  i_rx_valid,
    input  byte_t i_rx_byte,
    output logic  o_echo_valid,
    output byte_t o_echo_byte,
    output logic  o_result_valid,
    output byte_t o_result_byte
);

    parser_state_t state;
    digit_t        d1;        // first operand
    digit_t        d2;        // second operand
    logic          is_digit;
    logic          is_plus;
    logic          is_minus;
    logic          is_esc;
    byte_t         add_byte;  // '0' + d1 + d2, wraps at 256
    byte_t         sub_byte;  // '0' + d1 - d2, may drop below '0'

    // ------------------------------
    // character decode
    // ------------------------------
    assign is_digit = (i_rx_byte >= ASCII_ZERO) && (i_rx_byte <= ASCII_NINE);
    assign is_plus  = (i_rx_byte == ASCII_PLUS);
    assign is_minus = (i_rx_byte == ASCII_MINUS);
    assign is_esc   = (i_rx_byte == ASCII_ESC);

    assign add_byte = ASCII_ZERO + byte_t'(d1) + byte_t'(d2);
    assign sub_byte = ASCII_ZERO + byte_t'(d1) - byte_t'(d2);

    // ------------------------------
    // command FSM
    // ------------------------------
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            state          <= WAIT_D1;
            o_echo_valid   <= 1'b0;
            o_result_valid <= 1'b0;
        end else begin
            o_echo_valid   <= i_rx_valid && !is_esc;  // ESC never echoed
            o_result_valid <= 1'b0;
            if (i_rx_valid) begin
                state <= WAIT_D1;  // anything unexpected restarts
                case (state)
                    WAIT_D1: if (is_digit) state <= WAIT_D2;
                    WAIT_D2: if (is_digit) state <= WAIT_OP;
                    WAIT_OP: o_result_valid <= is_plus || is_minus;
                    default: state <= WAIT_D1;
                endcase
            end
        end
    end

    // operands and outgoing bytes
    always_ff @(posedge CLKOP) begin
        if (i_rx_valid) begin
            o_echo_byte <= i_rx_byte;
            if (state == WAIT_D1 && is_digit) begin
                d1 <= i_rx_byte[3:0];  // '0'..'9' low nibble is the value
            end
            if (state == WAIT_D2 && is_digit) begin
                d2 <= i_rx_byte[3:0];
            end
            if (state == WAIT_OP) begin
                o_result_byte <= is_minus ? sub_byte : add_byte;
            end
        end
    end

endmodule

//--- src/uart_tx_arbiter.sv
/*
 * transmit arbiter
 * one-byte echo and result slots, echo launched first so a
 * result always follows the echo of its operator
 */

`timescale 1ns/1ps

module uart_tx_arbiter import uart_calc_pkg::*; (
    input  logic  CLKOP,
    input  logic  i_rst,
    input  logic  i_echo_valid,
    input  byte_t i_echo_byte,
    input  logic  i_result_valid,
    input  byte_t i_result_byte,
    input  logic  i_tx_busy,
    output logic  o_tx_start,
    output byte_t o_tx_byte
);

    logic  echo_full;
    byte_t echo_data;
    logic  res_full;
    byte_t res_data;
    logic  launch;     // hand a byte to the transmitter
    logic  echo_take;  // echo slot emptied this cycle
    logic  res_take;   // result slot emptied this cycle
    logic  echo_fill;
    logic  res_fill;

    // busy rises a cycle after start, so skip the cycle right after a launch
    assign launch    = !i_tx_busy && !o_tx_start && (echo_full || res_full);
    assign echo_take = launch && echo_full;
    assign res_take  = launch && !echo_full;
    assign echo_fill = i_echo_valid && (!echo_full || echo_take);  // else dropped
    assign res_fill  = i_result_valid && (!res_full || res_take);

    // ------------------------------
    // slot flags and start strobe
    // ------------------------------
    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            echo_full  <= 1'b0;
            res_full   <= 1'b0;
            o_tx_start <= 1'b0;
        end else begin
            o_tx_start <= launch;
            echo_full  <= echo_fill || (echo_full && !echo_take);
            res_full   <= res_fill || (res_full && !res_take);
        end
    end

    always_ff @(posedge CLKOP) begin
        if (echo_fill) echo_data <= i_echo_byte;
        if (res_fill)  res_data  <= i_result_byte;
        if (launch)    o_tx_byte <= echo_full ? echo_data : res_data;  // echo wins
    end

    // parser outpacing the line would lose a byte here
    a_echo_no_drop: assert property (@(posedge CLKOP) disable iff (i_rst)
        i_echo_valid |-> (!echo_full || echo_take));
    a_res_no_drop: assert property (@(posedge CLKOP) disable iff (i_rst)
        i_result_valid |-> (!res_full || res_take));

endmodule

//--- src/uart_calc_top.sv
/*
 * serial calculator top level
 * rx -> command parser -> tx arbiter -> tx, one baud tick
 * generator shared by both ends of the link
 */

`timescale 1ns/1ps

module uart_calc_top import uart_calc_pkg::*; #(
    parameter int CLK_FREQ = 50_000_000,  // system clock in Hz
    parameter int BAUD     = 115_200
) (
    input  logic CLKOP,
    input  logic i_rst,
    input  logic i_rx,   // from host
    output logic o_tx    // to host
);

    logic  os_tick;
    logic  rx_valid;
    byte_t rx_byte;
    logic  echo_valid;
    byte_t echo_byte;
    logic  result_valid;
    byte_t result_byte;
    logic  tx_start;
    byte_t tx_byte;
    logic  tx_busy;

    // ------------------------------
    // timing
    // ------------------------------
    uart_baud_gen #(
        .CLK_FREQ (CLK_FREQ),
        .BAUD     (BAUD)
    ) u_baud_gen (
        .CLKOP     (CLKOP),
        .i_rst     (i_rst),
        .o_os_tick (os_tick)
    );

    // ------------------------------
    // receive and parse
    // ------------------------------
    uart_rx u_uart_rx (
        .CLKOP      (CLKOP),
        .i_rst      (i_rst),
        .i_os_tick  (os_tick),
        .i_rx       (i_rx),
        .o_rx_valid (rx_valid),
        .o_rx_byte  (rx_byte)
    );

    calc_cmd_parser u_parser (
        .CLKOP          (CLKOP),
        .i_rst          (i_rst),
        .i_rx_valid     (rx_valid),
        .i_rx_byte      (rx_byte),
        .o_echo_valid   (echo_valid),
        .o_echo_byte    (echo_byte),
        .o_result_valid (result_valid),
        .o_result_byte  (result_byte)
    );

    // ------------------------------
    // transmit path
    // ------------------------------
    uart_tx_arbiter u_tx_arbiter (
        .CLKOP          (CLKOP),
        .i_rst          (i_rst),
        .i_echo_valid   (echo_valid),
        .i_echo_byte    (echo_byte),
        .i_result_valid (result_valid),
        .i_result_byte  (result_byte),
        .i_tx_busy      (tx_busy),
        .o_tx_start     (tx_start),
        .o_tx_byte      (tx_byte)
    );

    uart_tx u_uart_tx (
        .CLKOP      (CLKOP),
        .i_rst      (i_rst),
        .i_os_tick  (os_tick),
        .i_tx_start (tx_start),
        .i_tx_byte  (tx_byte),
        .o_tx_busy  (tx_busy),
        .o_tx       (o_tx)
    );

endmodule

//--- verif/tb_uart_calc_top.sv
/*
 * testbench for the serial calculator
 * drives 8N1 frames into i_rx, decodes o_tx into a byte queue
 * and checks echoes and result bytes against the command rule
 */

`timescale 1ns/1ps

module tb_uart_calc_top import uart_calc_pkg::*; ();

    localparam int CLK_FREQ   = 50_000_000;
    localparam int BAUD       = 625_000;
    localparam int BIT_CYC    = CLK_FREQ / BAUD;  // 80 clocks per bit
    localparam int FRAME_CYC  = 10 * BIT_CYC;
    localparam int NUM_FRAMES = 147;              // sent, echoed, result and quiet frames
    localparam int WDOG_CYC   = NUM_FRAMES * FRAME_CYC + 5000;

    logic   CLKOP;
    logic   i_rst;
    logic   i_rx;
    logic   o_tx;
    byte_t  rx_q[$];     // bytes decoded from o_tx
    int     errors = 0;
    integer seed;

    uart_calc_top #(
        .CLK_FREQ (CLK_FREQ),
        .BAUD     (BAUD)       // divider of exactly 5
    ) u_uart_calc_top (
        .CLKOP (CLKOP),
        .i_rst (i_rst),
        .i_rx  (i_rx),
        .o_tx  (o_tx)
    );

    initial begin
        CLKOP = 1'b0;
        forever #10 CLKOP = ~CLKOP;  // 20 ns period
    end

    // watchdog sized from the frame count of all tests
    initial begin
        repeat (WDOG_CYC) @(posedge CLKOP);
        $display("timeout: tests did not finish within %0d cycles", WDOG_CYC);
        $display("TB FAILED");
        $finish;
    end

    // ------------------------------
    // serial monitor on o_tx
    // ------------------------------
    initial begin : tx_monitor
        byte_t data;
        @(negedge i_rst);
        forever begin
            @(negedge o_tx);                        // start bit edge
            repeat (BIT_CYC / 2) @(negedge CLKOP);  // to mid start bit
            if (o_tx) begin
                $display("t=%0t start bit on o_tx went back high", $time);
                errors++;
            end else begin
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CYC) @(negedge CLKOP);
                    data[i] = o_tx;                 // LSB first
                end
                repeat (BIT_CYC) @(negedge CLKOP);
                if (!o_tx) begin
                    $display("t=%0t stop bit on o_tx was low", $time);
                    errors++;
                end
                rx_q.push_back(data);
            end
        end
    end

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got 0x%02h exp 0x%02h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // '0' plus sum or difference, wraps at 256
    function automatic byte_t expected_result(input int a, input int b, input byte_t op);
        int v;
        v = int'(ASCII_ZERO) + ((op == ASCII_MINUS) ? (a - b) : (a + b));
        return byte_t'(v & 255);
    endfunction

    // ------------------------------
    // serial driver and helpers
    // ------------------------------
    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // stop, data, start
        for (int i = 0; i < 10; i++) begin
            @(posedge CLKOP);
            #2;
            i_rx = frame[i];
            repeat (BIT_CYC - 1) @(posedge CLKOP);
        end
    endtask

    task automatic send_string(input string s);
        for (int i = 0; i < s.len(); i++) send_byte(byte_t'(s[i]));
    endtask

    task automatic expect_byte(input byte_t exp_byte);
        int waited;
        waited = 0;
        while (rx_q.size() == 0 && waited < 3 * FRAME_CYC) begin
            @(posedge CLKOP);
            waited++;
        end
        if (rx_q.size() == 0) begin
            $display("t=%0t no byte arrived on o_tx, expected 0x%02h", $time, exp_byte);
            errors++;
        end else begin
            check_byte("o_tx", rx_q.pop_front(), exp_byte);
        end
    endtask

    task automatic expect_string(input string s);
        for (int i = 0; i < s.len(); i++) expect_byte(byte_t'(s[i]));
    endtask

    // nothing more within two frames
    task automatic expect_quiet();
        repeat (2 * FRAME_CYC) @(posedge CLKOP);
        if (rx_q.size() != 0) begin
            $display("t=%0t %0d unexpected byte(s) on o_tx, first 0x%02h",
                     $time, rx_q.size(), rx_q[0]);
            errors++;
            rx_q.delete();
        end
    endtask

    // one full command, four bytes back
    task automatic run_calc(input int a, input int b, input byte_t op);
        byte_t c1;
        byte_t c2;
        c1 = ASCII_ZERO + byte_t'(a);
        c2 = ASCII_ZERO + byte_t'(b);
        send_byte(c1);
        send_byte(c2);
        send_byte(op);
        expect_byte(c1);
        expect_byte(c2);
        expect_byte(op);
        expect_byte(expected_result(a, b, op));
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic idle_and_letters();
        repeat (100) begin
            @(negedge CLKOP);
            check_bit("o_tx", o_tx, 1'b1);  // idle line
        end
        send_string("ab");
        expect_string("ab");
        expect_quiet();
    endtask

    task automatic addition_cmds();
        run_calc(3, 4, ASCII_PLUS);
        run_calc(9, 9, ASCII_PLUS);   // '0'+18
    endtask

    task automatic subtraction_cmds();
        run_calc(7, 2, ASCII_MINUS);
        run_calc(2, 7, ASCII_MINUS);  // wraps below '0'
    endtask

    task automatic esc_mid_command();
        send_string("5");
        send_byte(ASCII_ESC);         // not echoed, drops the 5
        send_string("12+");
        expect_string("512+");
        expect_byte(expected_result(1, 2, ASCII_PLUS));
    endtask

    task automatic malformed_cmds();
        send_string("4x");
        send_string("43q");
        expect_string("4x43q");
        expect_quiet();               // no result byte
        run_calc(1, 1, ASCII_PLUS);
    endtask

    task automatic random_cmds();
        int    a;
        int    b;
        byte_t op;
        for (int n = 0; n < 12; n++) begin
            a  = int'($unsigned($random(seed)) % 10);
            b  = int'($unsigned($random(seed)) % 10);
            op = ($random(seed) & 1) ? ASCII_PLUS : ASCII_MINUS;
            run_calc(a, b, op);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        i_rst = 1'b1;
        i_rx  = 1'b1;       // line idle
        seed  = 32'heb54;
        repeat (5) @(posedge CLKOP);
        #2;
        i_rst = 1'b0;
        idle_and_letters();
        addition_cmds();
        subtraction_cmds();
        esc_mid_command();
        malformed_cmds();
        random_cmds();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- uart_calc_top.f
src/uart_calc_pkg.sv
src/uart_baud_gen.sv
src/uart_rx.sv
src/uart_tx.sv
src/calc_cmd_parser.sv
src/uart_tx_arbiter.sv
src/uart_calc_top.sv
verif/tb_uart_calc_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the serial calculator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f uart_calc_top.f \
    --top-module tb_uart_calc_top --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_sim 2>&1 | tee sim.log
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    echo "no pass line in sim.log"
    exit 1
fi
exit 0
